//--- compile.f
+incdir+hw
+incdir+verification
hw/exCorePkg.sv
hw/exAlu.sv
hw/exAgu.sv
hw/exEx1.sv
hw/exStageTop.sv
verification/exStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the EX1 stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

if ! verilator --binary --timing -j 0 --top-module exStageTb -f compile.f \
	--Mdir "$BUILD_DIR" -o exStageSim; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/exStageSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ "$simStatus" -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
fi

if ! grep -q "Verification passed" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi

echo "Simulation succeeded"
exit 0

//--- verification/exRefModel.svh
// Reference model of the EX1 stage for the testbench
// Expected-output record, ALU and compare rules, per-op prediction with its own T flag

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

typedef struct packed {
	logic [5:0]  idRn1;
	logic [63:0] valRn1;
	logic [5:0]  heldId;
	logic [4:0]  opm;
	logic [31:0] memAddr;
	logic [63:0] memData;
	logic        braValid;
	logic [31:0] braAddr;
	logic        srT;
} expT;

logic mdlT;	// Model copy of SR.T

function automatic logic [63:0] aluRef(input logic [2:0] fn, input logic [63:0] a, b);
	case (fn)
		3'd0: return a + b;
		3'd1: return a - b;
		3'd2: return a & b;
		3'd3: return a | b;
		3'd4: return a ^ b;
		3'd5: return a << b[5:0];
		3'd6: return a >> b[5:0];
		default: return $signed(a) >>> b[5:0];	// Arithmetic shift
	endcase
endfunction

function automatic logic cmpRef(input logic [1:0] fn, input logic [63:0] a, b);
	case (fn)
		2'd0: return a == b;
		2'd1: return $signed(a) > $signed(b);
		2'd2: return a > b;
		default: return (a & b) != 64'd0;	// TST
	endcase
endfunction

// Predicts the registered outputs one cycle after this op
task automatic modelStep(input logic [7:0] cmd, ixt, input logic [5:0] idRm,
		input logic [63:0] rs, rt, rm, input logic [31:0] pc, input logic [32:0] imm,
		output expT e);
	logic        en;
	logic [63:0] immSx;
	logic [31:0] ea;
	case (cmd[7:6])
		2'd0: en = 1'b1;
		2'd1: en = 1'b0;
		2'd2: en = mdlT;
		default: en = !mdlT;
	endcase
	immSx = {{31{imm[32]}}, imm};
	ea = rs[31:0] + (rt[31:0] << ixt[5:4]);	// Scaled index
	e = '0;
	e.idRn1 = 6'h3F;
	e.heldId = 6'h3F;
	e.memAddr = ea;
	e.memData = rm;
	if (en) begin
		case (cmd[5:0])
			ALU3: begin
				e.idRn1 = idRm;
				e.valRn1 = aluRef(ixt[2:0], rs, rt);
			end
			ALUCMP: begin
				mdlT = cmpRef(ixt[1:0], rs, rt);
			end
			LEA_MR: begin
				e.idRn1 = idRm;
				e.valRn1 = {32'd0, ea};
			end
			MOV_RM: begin
				e.opm = {2'b10, ixt[3], ixt[5:4]};
			end
			MOV_MR: begin
				e.opm = {2'b01, ixt[3], ixt[5:4]};
				e.heldId = idRm;
			end
			MOV_IR: begin
				e.idRn1 = idRm;
				e.valRn1 = immSx;
			end
			BRA: begin
				e.braValid = 1'b1;
				e.braAddr = pc + {immSx[30:0], 1'b0};	// Halfword displacement
			end
			JMP: begin
				e.braValid = 1'b1;
				e.braAddr = rs[31:0];
			end
			default: begin
			end
		endcase
	end
	e.srT = mdlT;
endtask

`endif

//--- verification/exStageTb.sv
// Testbench for the EX1 stage
// Clock, reset, random ops from a fixed seed, checks against the reference model

`default_nettype none

`include "exCore_params.svh"

module exStageTb
	import exCorePkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumOps = 2000;
	localparam int RstTimeout = 32;	// Cycles

	logic                   clock;
	logic                   rstN;
	logic [7:0]             opUCmd;
	logic [7:0]             opUIxt;
	logic [`EX_REGID_W-1:0] regIdRs;
	logic [`EX_REGID_W-1:0] regIdRt;
	logic [`EX_REGID_W-1:0] regIdRm;
	logic [`EX_DATA_W-1:0]  regValRs;
	logic [`EX_DATA_W-1:0]  regValRt;
	logic [`EX_DATA_W-1:0]  regValRm;
	logic [`EX_ADDR_W-1:0]  regValPc;
	logic [32:0]            regValImm;
	logic [`EX_REGID_W-1:0] regIdRn1;
	logic [`EX_DATA_W-1:0]  regValRn1;
	logic [`EX_REGID_W-1:0] heldIdRn1;
	logic [`EX_ADDR_W-1:0]  memAddr;
	memOpmT                 memOpm;
	logic [`EX_DATA_W-1:0]  memDataOut;
	logic                   braValid;
	logic [`EX_ADDR_W-1:0]  braAddr;
	logic                   srT;

	`include "exRefModel.svh"

	expT         expCur;
	expT         expPrev;
	expT         rstExp;
	logic        havePrev;
	int          waitCnt;
	logic [31:0] rnd;

	exStageTop DUT (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;	// 4 ns period
	end

	task automatic failValue(input string name, input logic [63:0] got, exp);
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("Verification failed");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic checkOutputs(input expT e);
		assert (regIdRn1 === e.idRn1)
			else failValue("regIdRn1", 64'(regIdRn1), 64'(e.idRn1));
		if (e.idRn1 != 6'h3F) begin	// Value only matters with a write
			assert (regValRn1 === e.valRn1)
				else failValue("regValRn1", regValRn1, e.valRn1);
		end
		assert (heldIdRn1 === e.heldId)
			else failValue("heldIdRn1", 64'(heldIdRn1), 64'(e.heldId));
		assert (memOpm === e.opm)
			else failValue("memOpm", 64'(memOpm), 64'(e.opm));
		if (e.opm != 5'd0) begin
			assert (memAddr === e.memAddr)
				else failValue("memAddr", 64'(memAddr), 64'(e.memAddr));
		end
		if (e.opm[4:3] == 2'b10) begin	// Store data
			assert (memDataOut === e.memData)
				else failValue("memDataOut", memDataOut, e.memData);
		end
		assert (braValid === e.braValid)
			else failValue("braValid", 64'(braValid), 64'(e.braValid));
		if (e.braValid) begin
			assert (braAddr === e.braAddr)
				else failValue("braAddr", 64'(braAddr), 64'(e.braAddr));
		end
		assert (srT === e.srT)
			else failValue("srT", 64'(srT), 64'(e.srT));
	endtask

	// Drives one random op on this edge and predicts its outputs
	task automatic driveRandomOp(output expT e);
		logic [7:0]  cmd;
		logic [7:0]  ixt;
		logic [5:0]  idRm;
		logic [63:0] rs;
		logic [63:0] rt;
		logic [63:0] rm;
		logic [31:0] pc;
		logic [32:0] imm;
		rnd = $urandom_range(0, 9);
		cmd[5:0] = (rnd == 32'd9) ? ALUCMP : rnd[5:0];	// Extra compares
		rnd = $urandom;
		cmd[7:6] = rnd[1:0];
		ixt = rnd[15:8];
		if (cmd[5:0] == ALUCMP) begin
			ixt[2] = 1'b0;	// Compare codes 0..3
		end
		idRm = rnd[21:16];
		rs = {$urandom, $urandom};
		rt = (rnd[24:22] == 3'd0) ? rs : {$urandom, $urandom};
		rm = {$urandom, $urandom};
		pc = $urandom;
		imm = {rnd[31], $urandom};
		opUCmd <= cmd;
		opUIxt <= ixt;
		regIdRs <= rnd[27:22];
		regIdRt <= rnd[30:25];
		regIdRm <= idRm;
		regValRs <= rs;
		regValRt <= rt;
		regValRm <= rm;
		regValPc <= pc;
		regValImm <= imm;
		modelStep(cmd, ixt, idRm, rs, rt, rm, pc, imm, e);
	endtask

	initial begin
		rnd = $urandom(32'h9313_d119);	// Seed the run
		mdlT = 1'b0;
		havePrev = 1'b0;
		rstExp = '0;
		rstExp.idRn1 = 6'h3F;
		rstExp.heldId = 6'h3F;
		rstN = 1'b0;
		opUCmd = 8'h00;
		opUIxt = 8'h00;
		regIdRs = '0;
		regIdRt = '0;
		regIdRm = '0;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		regValPc = '0;
		regValImm = '0;
		repeat (8) @(posedge clock);
		rstN <= 1'b1;
		waitCnt = 0;
		while (rstN !== 1'b1) begin
			if (waitCnt == RstTimeout) begin
				$display("Reset release not seen within %0d cycles", RstTimeout);
				$display("Verification failed");
				$fatal(1, "Reset wait timed out");
			end
			@(negedge clock);
			waitCnt++;
		end
		checkOutputs(rstExp);	// Values left by reset
		for (int i = 0; i < NumOps; i++) begin
			@(posedge clock);
			driveRandomOp(expCur);
			@(negedge clock);
			if (havePrev) begin
				checkOutputs(expPrev);
			end
			expPrev = expCur;
			havePrev = 1'b1;
		end
		@(posedge clock);
		@(negedge clock);
		checkOutputs(expPrev);	// Last op
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/exStageTop.sv
// EX1 stage top level
// ALU and AGU side by side, merged by the EX1 combiner

`default_nettype none

`include "exCore_params.svh"

module exStageTop
	import exCorePkg::*;
(
	input  logic                   clock,
	input  logic                   rstN,
	input  logic [7:0]             opUCmd,
	input  logic [7:0]             opUIxt,
	input  logic [`EX_REGID_W-1:0] regIdRs,	// ALU / base
	input  logic [`EX_REGID_W-1:0] regIdRt,	// ALU / index
	input  logic [`EX_REGID_W-1:0] regIdRm,	// Dest or store source
	input  logic [`EX_DATA_W-1:0]  regValRs,
	input  logic [`EX_DATA_W-1:0]  regValRt,
	input  logic [`EX_DATA_W-1:0]  regValRm,
	input  logic [`EX_ADDR_W-1:0]  regValPc,
	input  logic [32:0]            regValImm,
	output logic [`EX_REGID_W-1:0] regIdRn1,
	output logic [`EX_DATA_W-1:0]  regValRn1,
	output logic [`EX_REGID_W-1:0] heldIdRn1,
	output logic [`EX_ADDR_W-1:0]  memAddr,
	output memOpmT                 memOpm,
	output logic [`EX_DATA_W-1:0]  memDataOut,
	output logic                   braValid,
	output logic [`EX_ADDR_W-1:0]  braAddr,
	output logic                   srT
);

	logic [`EX_DATA_W-1:0] aluVal;
	logic                  aluCmpT;
	logic [`EX_ADDR_W-1:0] aguMemAddr;
	logic [`EX_ADDR_W-1:0] aguBraAddr;

	exAlu uAlu (
		.regValRs, .regValRt,
		.aluFn   (aluFnT'(opUIxt[2:0])),
		.aluVal, .aluCmpT
	);

	exAgu uAgu (
		.regValRs, .regValRt,
		.accSize   (opUIxt[5:4]),
		.regValPc, .regValImm,
		.aguMemAddr, .aguBraAddr
	);

	exEx1 uEx1 (
		.clock, .rstN, .opUCmd, .opUIxt, .regIdRm,
		.regValRs, .regValRm, .regValImm,
		.aluVal, .aluCmpT, .aguMemAddr, .aguBraAddr,
		.regIdRn1, .regValRn1, .heldIdRn1,
		.memAddr, .memOpm, .memDataOut,
		.braValid, .braAddr, .srT
	);

endmodule

`default_nettype wire

//--- hw/exEx1.sv
// EX1 combiner
// Predication against SR.T, per-opcode result selection
// SR.T flag register and all registered stage outputs

`default_nettype none

`include "exCore_params.svh"

module exEx1
	import exCorePkg::*;
(
	input  logic                   clock,
	input  logic                   rstN,
	input  logic [7:0]             opUCmd,	// [7:6] cond, [5:0] opcode
	input  logic [7:0]             opUIxt,	// Per-opcode extension
	input  logic [`EX_REGID_W-1:0] regIdRm,
	input  logic [`EX_DATA_W-1:0]  regValRs,
	input  logic [`EX_DATA_W-1:0]  regValRm,
	input  logic [32:0]            regValImm,
	input  logic [`EX_DATA_W-1:0]  aluVal,
	input  logic                   aluCmpT,
	input  logic [`EX_ADDR_W-1:0]  aguMemAddr,
	input  logic [`EX_ADDR_W-1:0]  aguBraAddr,
	output logic [`EX_REGID_W-1:0] regIdRn1,	// Destination ID
	output logic [`EX_DATA_W-1:0]  regValRn1,	// Destination value
	output logic [`EX_REGID_W-1:0] heldIdRn1,	// Load destination
	output logic [`EX_ADDR_W-1:0]  memAddr,
	output memOpmT                 memOpm,
	output logic [`EX_DATA_W-1:0]  memDataOut,
	output logic                   braValid,
	output logic [`EX_ADDR_W-1:0]  braAddr,
	output logic                   srT
);

	logic                   opEnable;
	ucmdT                   opCmd;	// NOP when suppressed
	logic [`EX_REGID_W-1:0] nxtIdRn1;
	logic [`EX_DATA_W-1:0]  nxtValRn1;
	logic [`EX_REGID_W-1:0] nxtHeldId;
	memOpmT                 nxtOpm;
	logic                   nxtBraValid;
	logic [`EX_ADDR_W-1:0]  nxtBraAddr;
	logic                   nxtSrT;

	// Predicate on the T value held before this op
	always_comb begin
		case (ccT'(opUCmd[7:6]))
			AL: opEnable = 1'b1;
			NV: opEnable = 1'b0;
			CT: opEnable = srT;
			CF: opEnable = !srT;
		endcase
		opCmd = opEnable ? ucmdT'(opUCmd[5:0]) : NOP;
	end

	always_comb begin
		nxtIdRn1    = `EX_REG_ZZR;	// No write by default
		nxtValRn1   = '0;
		nxtHeldId   = `EX_REG_ZZR;
		nxtOpm      = READY;
		nxtBraValid = 1'b0;
		nxtBraAddr  = '0;
		nxtSrT      = srT;
		case (opCmd)
			ALU3: begin
				nxtIdRn1  = regIdRm;
				nxtValRn1 = aluVal;
			end
			ALUCMP: begin
				nxtSrT = aluCmpT;
			end
			LEA_MR: begin
				nxtIdRn1  = regIdRm;
				nxtValRn1 = {{(`EX_DATA_W-`EX_ADDR_W){1'b0}}, aguMemAddr};
			end
			MOV_RM: begin
				nxtOpm = memOpmT'({2'b10, opUIxt[3], opUIxt[5:4]});
			end
			MOV_MR: begin
				nxtOpm    = memOpmT'({2'b01, opUIxt[3], opUIxt[5:4]});
				nxtHeldId = regIdRm;	// EX2 completes the load
			end
			MOV_IR: begin
				nxtIdRn1  = regIdRm;
				nxtValRn1 = {{(`EX_DATA_W-33){regValImm[32]}}, regValImm};
			end
			BRA: begin
				nxtBraValid = 1'b1;
				nxtBraAddr  = aguBraAddr;
			end
			JMP: begin
				nxtBraValid = 1'b1;
				nxtBraAddr  = regValRs[`EX_ADDR_W-1:0];
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			regIdRn1   <= `EX_REG_ZZR;
			regValRn1  <= '0;
			heldIdRn1  <= `EX_REG_ZZR;
			memAddr    <= '0;
			memOpm     <= READY;
			memDataOut <= '0;
			braValid   <= 1'b0;
			braAddr    <= '0;
			srT        <= 1'b0;
		end else begin
			regIdRn1   <= nxtIdRn1;
			regValRn1  <= nxtValRn1;
			heldIdRn1  <= nxtHeldId;
			memAddr    <= aguMemAddr;	// Only meaningful with a live opm
			memOpm     <= nxtOpm;
			memDataOut <= regValRm;	// Store data
			braValid   <= nxtBraValid;
			braAddr    <= nxtBraAddr;
			srT        <= nxtSrT;
		end
	end

endmodule

`default_nettype wire

//--- hw/exAgu.sv
// Combinational address generator for the EX1 stage
// Scaled-index load/store address and PC-relative branch target

`default_nettype none

`include "exCore_params.svh"

module exAgu (
	input  logic [`EX_DATA_W-1:0] regValRs,	// Base
	input  logic [`EX_DATA_W-1:0] regValRt,	// Index
	input  logic [1:0]            accSize,	// Log2 of access bytes
	input  logic [`EX_ADDR_W-1:0] regValPc,
	input  logic [32:0]           regValImm,
	output logic [`EX_ADDR_W-1:0] aguMemAddr,
	output logic [`EX_ADDR_W-1:0] aguBraAddr
);

	logic [`EX_ADDR_W-1:0] idxScaled;
	logic [`EX_DATA_W-1:0] immSext;
	logic [`EX_ADDR_W-1:0] braDisp;

	// Index scaled by the access size
	assign idxScaled  = regValRt[`EX_ADDR_W-1:0] << accSize;
	assign aguMemAddr = regValRs[`EX_ADDR_W-1:0] + idxScaled;

	// Displacement counts 16-bit words
	assign immSext    = {{(`EX_DATA_W-33){regValImm[32]}}, regValImm};
	assign braDisp    = {immSext[`EX_ADDR_W-2:0], 1'b0};
	assign aguBraAddr = regValPc + braDisp;

endmodule

`default_nettype wire

//--- hw/exAlu.sv
// Combinational ALU for the EX1 stage
// ADD/SUB, logic ops, 64-bit shifts and the four compares

`default_nettype none

`include "exCore_params.svh"

module exAlu
	import exCorePkg::*;
(
	input  logic [`EX_DATA_W-1:0] regValRs,	// Source A
	input  logic [`EX_DATA_W-1:0] regValRt,	// Source B
	input  aluFnT                 aluFn,
	output logic [`EX_DATA_W-1:0] aluVal,	// ALU3 result
	output logic                  aluCmpT	// Compare result
);

	logic [5:0]            shAmt;
	logic [`EX_DATA_W-1:0] andVal;

	assign shAmt  = regValRt[5:0];	// Only low 6 bits count
	assign andVal = regValRs & regValRt;	// Shared with TST

	always_comb begin
		case (aluFn)
			ADD: begin
				aluVal = regValRs + regValRt;
			end
			SUB: begin
				aluVal = regValRs - regValRt;
			end
			AND: begin
				aluVal = andVal;
			end
			OR: begin
				aluVal = regValRs | regValRt;
			end
			XOR: begin
				aluVal = regValRs ^ regValRt;
			end
			SHL: begin
				aluVal = regValRs << shAmt;
			end
			SHR: begin
				aluVal = regValRs >> shAmt;	// Zero fill
			end
			SAR: begin
				aluVal = $signed(regValRs) >>> shAmt;	// Sign fill
			end
			default: begin
				aluVal = '0;
			end
		endcase
	end

	// Upper codes have no compare meaning and give 0
	always_comb begin
		case (aluFn)
			CMPEQ: begin
				aluCmpT = (regValRs == regValRt);
			end
			CMPGT: begin
				aluCmpT = ($signed(regValRs) > $signed(regValRt));
			end
			CMPHI: begin
				aluCmpT = (regValRs > regValRt);
			end
			TST: begin
				aluCmpT = (andVal != '0);
			end
			default: begin
				aluCmpT = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/exCorePkg.sv
// Types for the EX1 stage
// Micro-op opcodes, condition codes, ALU functions, memory opm codes

`default_nettype none

package exCorePkg;

	typedef enum logic [5:0] {
		NOP    = 6'h00,	// Empty slot
		ALU3   = 6'h01,	// Rm = Rs op Rt
		ALUCMP = 6'h02,	// SR.T = Rs cmp Rt
		LEA_MR = 6'h03,	// Rm = address
		MOV_RM = 6'h04,	// Store Rm
		MOV_MR = 6'h05,	// Load into Rm
		MOV_IR = 6'h06,	// Rm = immediate
		BRA    = 6'h07,	// PC-relative branch
		JMP    = 6'h08	// Register jump
	} ucmdT;

	typedef enum logic [1:0] {
		AL = 2'd0,	// Always
		NV = 2'd1,	// Never
		CT = 2'd2,	// If SR.T set
		CF = 2'd3	// If SR.T clear
	} ccT;

	typedef enum logic [2:0] {
		ADD, SUB, AND, OR, XOR, SHL, SHR, SAR
	} aluFnT;

	// ALUCMP reuses the low function codes
	localparam aluFnT CMPEQ = ADD;
	localparam aluFnT CMPGT = SUB;	// Signed
	localparam aluFnT CMPHI = AND;	// Unsigned
	localparam aluFnT TST   = OR;	// AND nonzero

	// {dir[1:0], sign, size[1:0]}
	typedef enum logic [4:0] {
		READY = 5'b00000,
		RD_SB = 5'b01000, RD_SW, RD_SL, RD_SQ,
		RD_UB = 5'b01100, RD_UW, RD_UL, RD_UQ,
		WR_SB = 5'b10000, WR_SW, WR_SL, WR_SQ,
		WR_UB = 5'b10100, WR_UW, WR_UL, WR_UQ
	} memOpmT;

endpackage

`default_nettype wire

//--- hw/exCore_params.svh
// Width macros shared by the EX1 stage
// Register value, address/PC and register ID widths
// Zero-register ID used as "no destination"

`ifndef EX_CORE_PARAMS_SVH
`define EX_CORE_PARAMS_SVH

`define EX_DATA_W	64	// GPR value width
`define EX_ADDR_W	32	// Address and PC width
`define EX_REGID_W	6	// Register ID width

// Writes to this ID are dropped by the register file
`define EX_REG_ZZR	6'h3F

`endif
